//--- design/bpf_defs.svh
`ifndef BPF_DEFS_SVH
`define BPF_DEFS_SVH

// Memory sizes
`define BPF_CODE_AW     8
`define BPF_PKT_AW      8   // Packet is word addressed
`define BPF_SCRATCH_AW  4   // 16 scratch words

// Instruction class, opcode bits 2:0
`define BPF_CLASS_LD    3'h0
`define BPF_CLASS_LDX   3'h1
`define BPF_CLASS_ST    3'h2
`define BPF_CLASS_STX   3'h3
`define BPF_CLASS_ALU   3'h4
`define BPF_CLASS_JMP   3'h5
`define BPF_CLASS_RET   3'h6
`define BPF_CLASS_MISC  3'h7

// Load size, bits 4:3 (word only)
`define BPF_SIZE_W      2'h0

// Addressing mode, bits 7:5
`define BPF_MODE_IMM    3'h0
`define BPF_MODE_ABS    3'h1
`define BPF_MODE_IND    3'h2
`define BPF_MODE_MEM    3'h3
`define BPF_MODE_LEN    3'h4
`define BPF_MODE_MSH    3'h5

// ALU operation, bits 7:4
`define BPF_OP_ADD      4'h0
`define BPF_OP_SUB      4'h1
`define BPF_OP_OR       4'h4
`define BPF_OP_AND      4'h5
`define BPF_OP_LSH      4'h6
`define BPF_OP_RSH      4'h7
`define BPF_OP_NEG      4'h8
`define BPF_OP_XOR      4'ha

// Jump operation, bits 7:4
`define BPF_OP_JA       4'h0
`define BPF_OP_JEQ      4'h1
`define BPF_OP_JGT      4'h2
`define BPF_OP_JGE      4'h3
`define BPF_OP_JSET     4'h4

// MISC sub-op in bits 7:3
`define BPF_MISC_TAX    5'h00
`define BPF_MISC_TXA    5'h10

`define BPF_SRC_X       3   // X instead of K; RET X shares this bit
`define BPF_RVAL_A      4   // RET A instead of K

`endif

//--- design/bpf_pkg.sv
`default_nettype none

`include "bpf_defs.svh"

package bpf_pkg;

    typedef logic [31:0]                 word_t;
    typedef logic [`BPF_CODE_AW-1:0]     code_addr_t;
    typedef logic [`BPF_PKT_AW-1:0]      pkt_addr_t;
    typedef logic [`BPF_SCRATCH_AW-1:0]  scr_addr_t;
    typedef logic [63:0]                 insn_t;      // opcode 63:48, jt, jf, k 31:0

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LSH, ALU_RSH, ALU_NEG
    } alu_op_t;

    typedef enum logic [2:0] {
        A_SEL_IMM, A_SEL_PKT, A_SEL_MEM, A_SEL_LEN, A_SEL_ALU, A_SEL_X
    } a_sel_t;

    typedef enum logic [2:0] {
        X_SEL_IMM, X_SEL_PKT_MSH, X_SEL_MEM, X_SEL_LEN, X_SEL_A
    } x_sel_t;

    typedef enum logic [1:0] {PC_PLUS_1, PC_PLUS_JT, PC_PLUS_JF, PC_PLUS_K} pc_sel_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_MEM_WAIT, ST_ALU_WAIT, ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/bpf_sdp_ram.sv
`default_nettype none

// One write port, one registered read port
module bpf_sdp_ram #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [DEPTH_LOG2-1:0] wr_addr,
    input  logic [WIDTH-1:0]      wr_data,
    input  logic [DEPTH_LOG2-1:0] rd_addr,
    output logic [WIDTH-1:0]      rd_data
);

    logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2) - 1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // Old data on same-address write
    end

endmodule

`default_nettype wire

//--- design/bpf_alu.sv
`default_nettype none

module bpf_alu (
    input  logic             clk,
    input  logic             rst,
    input  bpf_pkg::word_t   a,
    input  bpf_pkg::word_t   b,
    input  bpf_pkg::alu_op_t alu_op,
    input  logic             alu_en,
    output bpf_pkg::word_t   result,
    output logic             eq,
    output logic             gt,
    output logic             ge,
    output logic             set,
    output logic             alu_vld,
    input  logic             alu_ack
);
    import bpf_pkg::*;

    logic       shifting;    // Iterative shift running
    logic       shift_left;
    logic [5:0] shift_cnt;   // Positions left
    logic [5:0] shift_amt;
    logic       is_shift;
    word_t      comb_res;

    assign is_shift  = (alu_op == ALU_LSH) || (alu_op == ALU_RSH);
    assign shift_amt = (b > 32'd32) ? 6'd32 : b[5:0];  // Saturate, result is zero anyway

    // Single-cycle ops
    always_comb begin
        case (alu_op)
            ALU_ADD: comb_res = a + b;
            ALU_SUB: comb_res = a - b;
            ALU_AND: comb_res = a & b;
            ALU_OR:  comb_res = a | b;
            ALU_XOR: comb_res = a ^ b;
            ALU_NEG: comb_res = -a;
            default: comb_res = a;  // Shift starting value
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shifting  <= 1'b0;
            shift_cnt <= '0;
            alu_vld   <= 1'b0;
        end else begin
            if (alu_vld && alu_ack) alu_vld <= 1'b0;
            if (alu_en) begin
                if (is_shift && shift_amt != 6'd0) begin
                    shifting  <= 1'b1;
                    shift_cnt <= shift_amt;
                end else begin
                    alu_vld <= 1'b1;  // Done next cycle
                end
            end else if (shifting) begin
                shift_cnt <= shift_cnt - 6'd1;
                if (shift_cnt == 6'd1) begin  // Last position
                    shifting <= 1'b0;
                    alu_vld  <= 1'b1;
                end
            end
        end
    end

    // Result and flags
    always_ff @(posedge clk) begin
        if (alu_en) begin
            result     <= comb_res;
            shift_left <= (alu_op == ALU_LSH);
            eq         <= (a == b);
            gt         <= (a > b);   // Unsigned compare
            ge         <= (a >= b);
            set        <= |(a & b);
        end else if (shifting) begin
            result <= shift_left ? (result << 1) : (result >> 1);
        end
    end

    // New command only once the previous result is consumed
    assert property (@(posedge clk) disable iff (rst) alu_en |-> !(shifting || alu_vld));

endmodule

`default_nettype wire

//--- design/bpf_datapath.sv
`default_nettype none

module bpf_datapath (
    input  logic                clk,
    input  logic                rst,
    input  logic                a_en,
    input  bpf_pkg::a_sel_t     a_sel,
    input  logic                x_en,
    input  bpf_pkg::x_sel_t     x_sel,
    input  logic                pc_en,
    input  bpf_pkg::pc_sel_t    pc_sel,
    input  logic                pc_clr,
    input  logic                alu_en,
    input  bpf_pkg::alu_op_t    alu_op,
    input  logic                alu_ack,
    input  logic                b_use_x,
    input  logic                scr_wr_en,
    input  logic                scr_src_x,
    input  logic                addr_ind,
    input  bpf_pkg::insn_t      insn,
    input  bpf_pkg::word_t      pkt_rd_data,
    input  bpf_pkg::word_t      pkt_len,
    output bpf_pkg::code_addr_t pc,
    output bpf_pkg::pkt_addr_t  pkt_rd_addr,
    output logic                eq,
    output logic                gt,
    output logic                ge,
    output logic                set,
    output logic                alu_vld,
    output bpf_pkg::word_t      a,
    output bpf_pkg::word_t      x
);
    import bpf_pkg::*;

    word_t      k;
    logic [7:0] jt;
    logic [7:0] jf;
    word_t      b_opnd;
    word_t      alu_res;
    word_t      scr_rd_data;
    word_t      scr_wr_data;
    scr_addr_t  scr_addr;
    code_addr_t pc_next;

    assign k  = insn[31:0];
    assign jt = insn[47:40];
    assign jf = insn[39:32];

    assign b_opnd      = b_use_x ? x : k;
    assign pkt_rd_addr = pkt_addr_t'(addr_ind ? x + k : k);  // Word index
    assign scr_addr    = scr_addr_t'(k);                     // Low bits of k
    assign scr_wr_data = scr_src_x ? x : a;
    assign pc_next     = pc + code_addr_t'(1);  // Offsets count from here

    // Accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            a <= '0;
        end else if (a_en) begin
            case (a_sel)
                A_SEL_IMM: a <= k;
                A_SEL_PKT: a <= pkt_rd_data;  // abs and ind alike
                A_SEL_MEM: a <= scr_rd_data;
                A_SEL_LEN: a <= pkt_len;
                A_SEL_ALU: a <= alu_res;
                A_SEL_X:   a <= x;            // TXA
                default:   a <= a;
            endcase
        end
    end

    // Index register
    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
        end else if (x_en) begin
            case (x_sel)
                X_SEL_IMM:     x <= k;
                X_SEL_PKT_MSH: x <= {26'b0, pkt_rd_data[3:0], 2'b0};  // 4 * low nibble
                X_SEL_MEM:     x <= scr_rd_data;
                X_SEL_LEN:     x <= pkt_len;
                X_SEL_A:       x <= a;                                // TAX
                default:       x <= x;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || pc_clr) begin
            pc <= '0;
        end else if (pc_en) begin
            case (pc_sel)
                PC_PLUS_1:  pc <= pc_next;
                PC_PLUS_JT: pc <= pc_next + code_addr_t'(jt);
                PC_PLUS_JF: pc <= pc_next + code_addr_t'(jf);
                PC_PLUS_K:  pc <= pc_next + code_addr_t'(k);  // ja
                default:    pc <= pc_next;
            endcase
        end
    end

    bpf_alu i_bpf_alu (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b_opnd),
        .alu_op  (alu_op),
        .alu_en  (alu_en),
        .result  (alu_res),
        .eq      (eq),
        .gt      (gt),
        .ge      (ge),
        .set     (set),
        .alu_vld (alu_vld),
        .alu_ack (alu_ack)
    );

    // Scratch memory M[]
    bpf_sdp_ram #(
        .WIDTH      ($bits(word_t)),
        .DEPTH_LOG2 ($bits(scr_addr_t))
    ) i_scratch_ram (
        .clk     (clk),
        .wr_en   (scr_wr_en),
        .wr_addr (scr_addr),
        .wr_data (scr_wr_data),
        .rd_addr (scr_addr),
        .rd_data (scr_rd_data)
    );

endmodule

`default_nettype wire

//--- design/bpf_controller.sv
`default_nettype none

`include "bpf_defs.svh"

module bpf_controller (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             verdict_ack,
    input  bpf_pkg::insn_t   code_rd_data,
    input  logic             eq,
    input  logic             gt,
    input  logic             ge,
    input  logic             set,
    input  logic             alu_vld,
    input  bpf_pkg::word_t   a,
    input  bpf_pkg::word_t   x,
    output logic             a_en,
    output bpf_pkg::a_sel_t  a_sel,
    output logic             x_en,
    output bpf_pkg::x_sel_t  x_sel,
    output logic             pc_en,
    output bpf_pkg::pc_sel_t pc_sel,
    output logic             pc_clr,
    output logic             alu_en,
    output bpf_pkg::alu_op_t alu_op,
    output logic             alu_ack,
    output logic             b_use_x,
    output logic             scr_wr_en,
    output logic             scr_src_x,
    output logic             addr_ind,
    output bpf_pkg::insn_t   insn,
    output logic             busy,
    output logic             verdict_vld,
    output bpf_pkg::word_t   verdict
);
    import bpf_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    insn_t       ir;          // Held past decode
    logic [7:0]  op8;         // Classic BPF code byte
    logic [2:0]  cls;
    logic [2:0]  mode;
    logic [3:0]  op;
    logic        alu_ok;
    logic        taken;
    logic        ret_load;
    word_t       ret_val;

    assign insn = (state == ST_DECODE) ? code_rd_data : ir;  // Fresh word during decode
    assign op8  = insn[55:48];
    assign cls  = op8[2:0];
    assign mode = op8[7:5];
    assign op   = op8[7:4];

    assign b_use_x     = op8[`BPF_SRC_X];
    assign addr_ind    = (mode == `BPF_MODE_IND);
    assign scr_src_x   = (cls == `BPF_CLASS_STX);
    assign busy        = (state != ST_IDLE);
    assign verdict_vld = (state == ST_DONE);
    assign pc_clr      = (state == ST_IDLE) && start;

    always_comb begin
        alu_ok = 1'b1;
        case (op)
            `BPF_OP_ADD: alu_op = ALU_ADD;
            `BPF_OP_SUB: alu_op = ALU_SUB;
            `BPF_OP_AND: alu_op = ALU_AND;
            `BPF_OP_OR:  alu_op = ALU_OR;
            `BPF_OP_XOR: alu_op = ALU_XOR;
            `BPF_OP_LSH: alu_op = ALU_LSH;
            `BPF_OP_RSH: alu_op = ALU_RSH;
            `BPF_OP_NEG: alu_op = ALU_NEG;
            default: begin
                alu_op = ALU_SUB;           // Jumps only use the flags
                alu_ok = 1'b0;              // mul, div, mod
            end
        endcase
        case (op)
            `BPF_OP_JEQ: taken = eq;
            `BPF_OP_JGT: taken = gt;
            `BPF_OP_JGE: taken = ge;
            default:     taken = set;       // jset
        endcase
    end

    always_comb begin
        next_state = state;
        a_en       = 1'b0;
        a_sel      = A_SEL_IMM;
        x_en       = 1'b0;
        x_sel      = X_SEL_IMM;
        pc_en      = 1'b0;
        pc_sel     = PC_PLUS_1;
        alu_en     = 1'b0;
        alu_ack    = 1'b0;
        scr_wr_en  = 1'b0;
        ret_load   = 1'b0;
        ret_val    = '0;
        case (state)
            ST_IDLE:  if (start) next_state = ST_FETCH;
            ST_FETCH: next_state = ST_DECODE;          // Code RAM read in flight
            ST_DECODE: begin
                next_state = ST_FETCH;
                pc_en      = 1'b1;
                case (cls)
                    `BPF_CLASS_LD: begin
                        a_en = 1'b1;
                        if (mode == `BPF_MODE_LEN) a_sel = A_SEL_LEN;
                        if (mode == `BPF_MODE_MEM || ((mode == `BPF_MODE_ABS
                                || addr_ind) && op8[4:3] == `BPF_SIZE_W)) begin
                            a_en       = 1'b0;          // Wait for RAM
                            pc_en      = 1'b0;
                            next_state = ST_MEM_WAIT;
                        end else if (mode != `BPF_MODE_IMM && mode != `BPF_MODE_LEN) begin
                            next_state = ST_DONE;       // Bad load
                        end
                    end
                    `BPF_CLASS_LDX: begin
                        x_en = 1'b1;
                        if (mode == `BPF_MODE_LEN) x_sel = X_SEL_LEN;
                        if (mode == `BPF_MODE_MEM || mode == `BPF_MODE_MSH) begin
                            x_en       = 1'b0;
                            pc_en      = 1'b0;
                            next_state = ST_MEM_WAIT;
                        end else if (mode != `BPF_MODE_IMM && mode != `BPF_MODE_LEN) begin
                            next_state = ST_DONE;
                        end
                    end
                    `BPF_CLASS_ST, `BPF_CLASS_STX: scr_wr_en = 1'b1;
                    `BPF_CLASS_ALU, `BPF_CLASS_JMP: begin
                        pc_sel = PC_PLUS_K;             // ja
                        if (cls == `BPF_CLASS_ALU ? alu_ok : op != `BPF_OP_JA) begin
                            pc_en      = 1'b0;
                            alu_en     = 1'b1;
                            next_state = ST_ALU_WAIT;
                        end
                        if (cls == `BPF_CLASS_ALU ? !alu_ok : op > `BPF_OP_JSET) begin
                            pc_en      = 1'b0;
                            next_state = ST_DONE;
                        end
                    end
                    `BPF_CLASS_RET: begin
                        pc_en      = 1'b0;
                        next_state = ST_DONE;
                        ret_val    = op8[`BPF_RVAL_A] ? a : op8[`BPF_SRC_X] ? x : insn[31:0];
                    end
                    default: begin                      // MISC
                        a_sel = A_SEL_X;
                        x_sel = X_SEL_A;
                        a_en  = (op8[7:3] == `BPF_MISC_TXA);
                        x_en  = (op8[7:3] == `BPF_MISC_TAX);
                        if (!a_en && !x_en) next_state = ST_DONE;
                    end
                endcase
                if (next_state == ST_DONE) begin       // Verdict, zero for a bad opcode
                    {a_en, x_en, pc_en, scr_wr_en, alu_en} = '0;
                    ret_load = 1'b1;
                end
            end
            ST_MEM_WAIT: begin
                next_state = ST_FETCH;
                pc_en      = 1'b1;
                a_en       = (cls == `BPF_CLASS_LD);
                x_en       = (cls == `BPF_CLASS_LDX);
                a_sel      = (mode == `BPF_MODE_MEM) ? A_SEL_MEM : A_SEL_PKT;
                x_sel      = (mode == `BPF_MODE_MEM) ? X_SEL_MEM : X_SEL_PKT_MSH;
            end
            ST_ALU_WAIT: if (alu_vld) begin
                next_state = ST_FETCH;
                alu_ack    = 1'b1;
                pc_en      = 1'b1;
                a_sel      = A_SEL_ALU;
                a_en       = (cls == `BPF_CLASS_ALU);
                if (cls == `BPF_CLASS_JMP) pc_sel = taken ? PC_PLUS_JT : PC_PLUS_JF;
            end
            default: if (verdict_ack) next_state = ST_IDLE;  // Done, hold until ack
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= ST_IDLE;
        else     state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (state == ST_DECODE) ir <= code_rd_data;
        if (ret_load) verdict <= ret_val;
    end

    // Verdict held steady under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        verdict_vld && !verdict_ack |=> verdict_vld && $stable(verdict));

endmodule

`default_nettype wire

//--- design/bpf_filter_core.sv
`default_nettype none

module bpf_filter_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                code_wr_en,
    input  bpf_pkg::code_addr_t code_wr_addr,
    input  bpf_pkg::insn_t      code_wr_data,
    input  logic                pkt_wr_en,
    input  bpf_pkg::pkt_addr_t  pkt_wr_addr,
    input  bpf_pkg::word_t      pkt_wr_data,
    input  bpf_pkg::word_t      pkt_len,
    input  logic                start,
    output logic                busy,
    output logic                verdict_vld,
    output bpf_pkg::word_t      verdict,
    input  logic                verdict_ack
);
    import bpf_pkg::*;

    a_sel_t     a_sel;
    x_sel_t     x_sel;
    pc_sel_t    pc_sel;
    alu_op_t    alu_op;
    insn_t      code_rd_data;
    insn_t      insn;
    word_t      pkt_rd_data;
    word_t      a;
    word_t      x;
    code_addr_t pc;
    pkt_addr_t  pkt_rd_addr;
    logic       a_en, x_en, pc_en, pc_clr, alu_en, alu_ack, alu_vld;
    logic       b_use_x, scr_wr_en, scr_src_x, addr_ind;
    logic       eq, gt, ge, set;

    bpf_controller i_bpf_controller (.*);

    bpf_datapath i_bpf_datapath (.*);

    // Program store, read at pc
    bpf_sdp_ram #(
        .WIDTH      ($bits(insn_t)),
        .DEPTH_LOG2 ($bits(code_addr_t))
    ) i_code_ram (
        .clk     (clk),
        .wr_en   (code_wr_en),
        .wr_addr (code_wr_addr),
        .wr_data (code_wr_data),
        .rd_addr (pc),
        .rd_data (code_rd_data)
    );

    bpf_sdp_ram #(
        .WIDTH      ($bits(word_t)),
        .DEPTH_LOG2 ($bits(pkt_addr_t))
    ) i_pkt_ram (
        .clk     (clk),
        .wr_en   (pkt_wr_en),
        .wr_addr (pkt_wr_addr),
        .wr_data (pkt_wr_data),
        .rd_addr (pkt_rd_addr),
        .rd_data (pkt_rd_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_bpf_filter_core.sv
`default_nettype none

`include "bpf_defs.svh"

module tb_bpf_filter_core;
    import bpf_pkg::*;

    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 200;
    localparam int CLK_PERIOD  = 20;

    logic       clk;
    logic       rst;
    logic       code_wr_en;
    code_addr_t code_wr_addr;
    insn_t      code_wr_data;
    logic       pkt_wr_en;
    pkt_addr_t  pkt_wr_addr;
    word_t      pkt_wr_data;
    word_t      pkt_len;
    logic       start;
    logic       busy;
    logic       verdict_vld;
    word_t      verdict;
    logic       verdict_ack;

    integer seed = 32'h9213_ff56;
    int     errors = 0;
    int     checks = 0;
    int     prog_len;            // Next code address to load
    word_t  pkt_shadow [0:15];   // Copy of the packet words written

    // Opcode encodings, classic BPF
    localparam logic [15:0] LD_IMM  = {8'h0, `BPF_MODE_IMM, 2'b00, `BPF_CLASS_LD};
    localparam logic [15:0] LD_ABS  = {8'h0, `BPF_MODE_ABS, 2'b00, `BPF_CLASS_LD};
    localparam logic [15:0] LD_IND  = {8'h0, `BPF_MODE_IND, 2'b00, `BPF_CLASS_LD};
    localparam logic [15:0] LD_MEM  = {8'h0, `BPF_MODE_MEM, 2'b00, `BPF_CLASS_LD};
    localparam logic [15:0] LD_LEN  = {8'h0, `BPF_MODE_LEN, 2'b00, `BPF_CLASS_LD};
    localparam logic [15:0] LDX_IMM = {8'h0, `BPF_MODE_IMM, 2'b00, `BPF_CLASS_LDX};
    localparam logic [15:0] LDX_MEM = {8'h0, `BPF_MODE_MEM, 2'b00, `BPF_CLASS_LDX};
    localparam logic [15:0] ST      = {13'h0, `BPF_CLASS_ST};
    localparam logic [15:0] STX     = {13'h0, `BPF_CLASS_STX};
    localparam logic [15:0] RET_K   = {13'h0, `BPF_CLASS_RET};
    localparam logic [15:0] RET_A   = {11'h0, 1'b1, 1'b0, `BPF_CLASS_RET};
    localparam logic [15:0] TAX     = {8'h0, `BPF_MISC_TAX, `BPF_CLASS_MISC};
    localparam logic [15:0] TXA     = {8'h0, `BPF_MISC_TXA, `BPF_CLASS_MISC};

    bpf_filter_core i_bpf_filter_core (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog sized from the test budget
    initial begin
        #((16 + N_TESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [15:0] alu_code(input logic [3:0] op, input logic src_x);
        return {8'h0, op, src_x, `BPF_CLASS_ALU};
    endfunction

    function automatic logic [15:0] jmp_code(input logic [3:0] op, input logic src_x);
        return {8'h0, op, src_x, `BPF_CLASS_JMP};
    endfunction

    // Branch rule, unsigned compare of A with K or X
    function automatic logic jump_taken(input logic [3:0] op, input word_t av, input word_t bv);
        case (op)
            `BPF_OP_JGT:  return av > bv;
            `BPF_OP_JGE:  return av >= bv;
            `BPF_OP_JSET: return (av & bv) != 0;
            default:      return av == bv;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic emit(input logic [15:0] code, input logic [7:0] jt, input logic [7:0] jf,
                        input word_t k);
        @(posedge clk);
        code_wr_en   <= 1'b1;
        code_wr_addr <= code_addr_t'(prog_len);
        code_wr_data <= {code, jt, jf, k};
        prog_len++;
    endtask

    task automatic put_pkt(input int idx, input word_t data);
        @(posedge clk);
        pkt_wr_en   <= 1'b1;
        pkt_wr_addr <= pkt_addr_t'(idx);
        pkt_wr_data <= data;
        if (idx < 16) pkt_shadow[idx] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        code_wr_en <= 1'b0;
        pkt_wr_en  <= 1'b0;
        prog_len = 0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_verdict(output word_t v);
        int cycles;
        cycles = 0;
        while (!verdict_vld && cycles < 400) begin
            @(posedge clk);
            cycles++;
        end
        checks++;
        assert (verdict_vld) else begin
            errors++;
            $display("No verdict within 400 cycles of start");
        end
        v = verdict;
    endtask

    task automatic ack_verdict();
        verdict_ack <= 1'b1;  // Right after an edge, seen at the next one
        @(posedge clk);
        verdict_ack <= 1'b0;
    endtask

    task automatic run_filter(output word_t v);
        pulse_start();
        wait_verdict(v);
        ack_verdict();
    endtask

    task automatic test_ret();
        word_t v;
        emit(RET_K, 8'h0, 8'h0, 32'h0000_1234);
        end_writes();
        run_filter(v);
        check_word("verdict (RET K)", v, 32'h0000_1234);
        pkt_len <= 32'h0000_005c;
        emit(LD_LEN, 8'h0, 8'h0, 32'h0);
        emit(RET_A, 8'h0, 8'h0, 32'h0);
        end_writes();
        run_filter(v);
        check_word("verdict (RET A of len)", v, 32'h0000_005c);
    endtask

    task automatic test_ethertype();
        word_t v;
        word_t w;
        word_t match;
        match = 32'h0800_4500;
        for (int i = 0; i < 3; i++) put_pkt(i, $random(seed));
        put_pkt(3, match);
        emit(LD_ABS, 8'h0, 8'h0, 32'd3);
        emit(jmp_code(`BPF_OP_JEQ, 1'b0), 8'd0, 8'd1, match);
        emit(RET_K, 8'h0, 8'h0, 32'd64);
        emit(RET_K, 8'h0, 8'h0, 32'd0);
        end_writes();
        run_filter(v);
        check_word("verdict (ethertype match)", v, 32'd64);
        w = $random(seed);
        if (w == match) w = ~w;         // Force a miss
        put_pkt(3, w);
        end_writes();
        run_filter(v);
        check_word("verdict (ethertype miss)", v, (w == match) ? 32'd64 : 32'd0);
    endtask

    task automatic test_alu_chain();
        word_t v;
        word_t acc;
        word_t k0;
        word_t xv;
        k0  = $random(seed);
        xv  = 32'd3;
        acc = k0;
        acc = acc + 32'h0001_0f0f;
        acc = acc - xv;
        acc = acc & 32'hf0ff_7fff;
        acc = acc | xv;
        acc = acc ^ 32'h5a5a_a5a5;
        acc = acc << 5;
        acc = acc >> xv;
        acc = -acc;
        acc = acc >> 12;
        acc = acc << 1;
        emit(LD_IMM, 8'h0, 8'h0, k0);
        emit(LDX_IMM, 8'h0, 8'h0, xv);
        emit(alu_code(`BPF_OP_ADD, 1'b0), 8'h0, 8'h0, 32'h0001_0f0f);
        emit(alu_code(`BPF_OP_SUB, 1'b1), 8'h0, 8'h0, 32'h0);
        emit(alu_code(`BPF_OP_AND, 1'b0), 8'h0, 8'h0, 32'hf0ff_7fff);
        emit(alu_code(`BPF_OP_OR, 1'b1), 8'h0, 8'h0, 32'h0);
        emit(alu_code(`BPF_OP_XOR, 1'b0), 8'h0, 8'h0, 32'h5a5a_a5a5);
        emit(alu_code(`BPF_OP_LSH, 1'b0), 8'h0, 8'h0, 32'd5);
        emit(alu_code(`BPF_OP_RSH, 1'b1), 8'h0, 8'h0, 32'h0);
        emit(alu_code(`BPF_OP_NEG, 1'b0), 8'h0, 8'h0, 32'h0);
        emit(alu_code(`BPF_OP_RSH, 1'b0), 8'h0, 8'h0, 32'd12);
        emit(alu_code(`BPF_OP_LSH, 1'b0), 8'h0, 8'h0, 32'd1);
        emit(RET_A, 8'h0, 8'h0, 32'h0);
        end_writes();
        run_filter(v);
        check_word("verdict (ALU chain)", v, acc);
    endtask

    task automatic test_scratch();
        word_t v;
        int    xf;
        for (int i = 0; i < 16; i++) put_pkt(i, $random(seed));
        xf = (6 + 3) - 8;               // X built through M[], TAX and TXA
        emit(LD_IMM, 8'h0, 8'h0, 32'd3);
        emit(ST, 8'h0, 8'h0, 32'd2);
        emit(LDX_IMM, 8'h0, 8'h0, 32'd6);
        emit(STX, 8'h0, 8'h0, 32'd9);
        emit(LD_MEM, 8'h0, 8'h0, 32'd9);
        emit(LDX_MEM, 8'h0, 8'h0, 32'd2);
        emit(alu_code(`BPF_OP_ADD, 1'b1), 8'h0, 8'h0, 32'h0);
        emit(TAX, 8'h0, 8'h0, 32'h0);
        emit(LD_IMM, 8'h0, 8'h0, 32'd0);
        emit(TXA, 8'h0, 8'h0, 32'h0);
        emit(alu_code(`BPF_OP_SUB, 1'b0), 8'h0, 8'h0, 32'd8);
        emit(TAX, 8'h0, 8'h0, 32'h0);
        emit(LD_IND, 8'h0, 8'h0, 32'd4);
        emit(RET_A, 8'h0, 8'h0, 32'h0);
        end_writes();
        run_filter(v);
        check_word("verdict (scratch, LD ind)", v, pkt_shadow[xf + 4]);
    endtask

    task automatic jump_case(input int id, input logic [3:0] op, input logic src_x,
                             input word_t av, input word_t xv, input word_t k);
        word_t v;
        word_t exp;
        exp = jump_taken(op, av, src_x ? xv : k) ? (32'h0000_a000 | id) : (32'h0000_b000 | id);
        emit(LD_IMM, 8'h0, 8'h0, av);
        emit(LDX_IMM, 8'h0, 8'h0, xv);
        emit(jmp_code(op, src_x), 8'd0, 8'd1, k);
        emit(RET_K, 8'h0, 8'h0, 32'h0000_a000 | id);
        emit(RET_K, 8'h0, 8'h0, 32'h0000_b000 | id);
        end_writes();
        run_filter(v);
        check_word($sformatf("verdict (jump case %0d)", id), v, exp);
    endtask

    task automatic test_jumps();
        jump_case(0, `BPF_OP_JGT, 1'b0, 32'h8000_0000, 32'd0, 32'd1);
        jump_case(1, `BPF_OP_JGT, 1'b0, 32'd5, 32'd0, 32'd5);
        jump_case(2, `BPF_OP_JGT, 1'b1, 32'd9, 32'd4, 32'd100);
        jump_case(3, `BPF_OP_JGT, 1'b1, 32'd4, 32'hffff_fff0, 32'd0);
        jump_case(4, `BPF_OP_JGE, 1'b0, 32'd5, 32'd0, 32'd5);
        jump_case(5, `BPF_OP_JGE, 1'b0, 32'd4, 32'd0, 32'd5);
        jump_case(6, `BPF_OP_JGE, 1'b1, 32'd7, 32'd7, 32'd99);
        jump_case(7, `BPF_OP_JGE, 1'b1, 32'd6, 32'd7, 32'd0);
        jump_case(8, `BPF_OP_JSET, 1'b0, 32'h0000_0f10, 32'd0, 32'h0000_0010);
        jump_case(9, `BPF_OP_JSET, 1'b0, 32'h0000_0f0f, 32'd0, 32'h0000_00f0);
        jump_case(10, `BPF_OP_JSET, 1'b1, 32'h8000_0001, 32'h8000_0000, 32'd0);
        jump_case(11, `BPF_OP_JSET, 1'b1, 32'h0000_0001, 32'h0000_0002, 32'hffff_ffff);
    endtask

    task automatic test_backpressure();
        word_t v1;
        word_t v2;
        word_t exp;
        int    hold;
        put_pkt(0, $random(seed));
        exp  = pkt_shadow[0] & 32'h0000_0fff;
        emit(LD_ABS, 8'h0, 8'h0, 32'd0);
        emit(alu_code(`BPF_OP_LSH, 1'b0), 8'h0, 8'h0, 32'd20);
        emit(alu_code(`BPF_OP_RSH, 1'b0), 8'h0, 8'h0, 32'd20);
        emit(RET_A, 8'h0, 8'h0, 32'h0);
        end_writes();
        pulse_start();
        repeat (3) @(posedge clk);
        check_word("busy (running)", 32'(busy), 32'd1);
        pulse_start();                  // Ignored while busy
        wait_verdict(v1);
        check_word("verdict (first run)", v1, exp);
        hold = ($random(seed) & 15) + 2;
        start <= 1'b1;                  // Ignored while the verdict waits
        repeat (hold) begin
            @(posedge clk);
            start <= 1'b0;
            check_word("verdict_vld (held)", 32'(verdict_vld), 32'd1);
            check_word("verdict (held)", verdict, exp);
            check_word("busy (held)", 32'(busy), 32'd1);
        end
        ack_verdict();
        repeat (4) @(posedge clk);
        check_word("busy (after ack)", 32'(busy), 32'd0);
        check_word("verdict_vld (after ack)", 32'(verdict_vld), 32'd0);
        run_filter(v2);
        check_word("verdict (second run)", v2, exp);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        code_wr_en   = 1'b0;
        code_wr_addr = '0;
        code_wr_data = '0;
        pkt_wr_en    = 1'b0;
        pkt_wr_addr  = '0;
        pkt_wr_data  = '0;
        pkt_len      = '0;
        start        = 1'b0;
        verdict_ack  = 1'b0;
        prog_len     = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_ret();
        test_ethertype();
        test_alu_chain();
        test_scratch();
        test_jumps();
        test_backpressure();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/bpf_pkg.sv
design/bpf_sdp_ram.sv
design/bpf_alu.sv
design/bpf_datapath.sv
design/bpf_controller.sv
design/bpf_filter_core.sv
bench/tb_bpf_filter_core.sv

//--- run.sh
#!/bin/sh
# Build and run the BPF filter core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_bpf_filter_core -o sim_bpf

out=$(./obj_dir/sim_bpf)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"
